// File: src/idct_pkg.sv
package idct_pkg;

	localparam int SAMPLE_W = 16;     // S' sample, signed
	localparam int COEF_W = 12;       // Cosine coefficient, signed
	localparam int T_W = 32;          // Result, signed
	localparam int BLOCK_N = 8;       // Block edge
	localparam int SRAM_ADDR_W = 18;
	localparam int RAM_ADDR_W = 5;    // 32 words of S' pairs
	localparam int SRAM_LATENCY = 2;  // Address to read data, in cycles

	// One RAM word, seen either raw or as two samples
	typedef union packed {
		logic [2*SAMPLE_W-1:0] raw;
		struct packed {
			logic signed [SAMPLE_W-1:0] first;   // Even column
			logic signed [SAMPLE_W-1:0] second;  // Odd column
		} pair;
	} sample_pair_u;

	// Indexed by {k, c}
	// Entry is 2048 * ck * cos((2c+1)k*pi/16) truncated toward zero, c0 = 1/sqrt(2)
	localparam logic signed [COEF_W-1:0] COS_TABLE [64] = '{
		1448,  1448,  1448,  1448,  1448,  1448,  1448,  1448,
		2008,  1702,  1137,   399,  -399, -1137, -1702, -2008,
		1892,   783,  -783, -1892, -1892,  -783,   783,  1892,
		1702,  -399, -2008, -1137,  1137,  2008,   399, -1702,
		1448, -1448, -1448,  1448,  1448, -1448, -1448,  1448,
		1137, -2008,   399,  1702, -1702,  -399,  2008, -1137,
		 783, -1892,  1892,  -783,  -783,  1892, -1892,   783,
		 399, -1137,  1702, -2008,  2008, -1702,  1137,  -399
	};

	function automatic logic signed [COEF_W-1:0] cos_coef(
		input logic [2:0] k,
		input logic [2:0] c
	);
		return COS_TABLE[{k, c}];
	endfunction

endpackage

// File: src/sprime_if.sv
interface sprime_if;
	import idct_pkg::*;

	// Fill side, shares port b of the RAM
	logic wr_en;
	logic [RAM_ADDR_W-1:0] wr_addr;
	sample_pair_u wr_data;

	// Scan side
	logic [RAM_ADDR_W-1:0] rd_addr_a;
	logic [RAM_ADDR_W-1:0] rd_addr_b;
	sample_pair_u rd_data_a;  // One cycle after rd_addr_a
	sample_pair_u rd_data_b;

	modport fill (
		output wr_en, wr_addr, wr_data
	);

	modport scan (
		output rd_addr_a, rd_addr_b,
		input rd_data_a, rd_data_b
	);

	modport mem (
		input wr_en, wr_addr, wr_data, rd_addr_a, rd_addr_b,
		output rd_data_a, rd_data_b
	);

endinterface

// File: src/block_fetch.sv
module block_fetch #(
	parameter int unsigned ROW_STRIDE = 320
) (
	input logic Clock,
	input logic Resetn,
	input logic start,
	input logic [idct_pkg::SRAM_ADDR_W-1:0] block_base,
	input logic [idct_pkg::SAMPLE_W-1:0] sram_read_data,
	input logic block_done,
	output logic [idct_pkg::SRAM_ADDR_W-1:0] sram_address,
	output logic busy,
	output logic block_loaded,
	sprime_if.fill ram
);
	import idct_pkg::*;

	localparam int CNT_W = $clog2(BLOCK_N);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(BLOCK_N - 1);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_FETCH = 2'd1;
	localparam logic [1:0] S_WAIT_DONE = 2'd2;  // Block held for the transform

	logic [1:0] state;
	logic [CNT_W-1:0] row;
	logic [CNT_W-1:0] col;
	logic addr_live;                   // sram_address holds a block address
	logic [SRAM_LATENCY-1:0] data_live;
	logic data_valid;
	logic odd;                         // Next sample arriving is an odd column
	logic [SRAM_ADDR_W-1:0] row_base;
	logic [SRAM_ADDR_W-1:0] next_row;
	logic [SAMPLE_W-1:0] even_buf;

	assign next_row = row_base + SRAM_ADDR_W'(ROW_STRIDE);
	assign data_valid = data_live[SRAM_LATENCY-1];

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_IDLE;
			busy <= 1'b0;
			sram_address <= '0;
			row <= '0;
			col <= '0;
			addr_live <= 1'b0;
			block_loaded <= 1'b0;
		end else begin
			block_loaded <= 1'b0;
			case (state)
			S_IDLE: begin
				if (start) begin
					sram_address <= block_base;
					row <= '0;
					col <= '0;
					addr_live <= 1'b1;
					busy <= 1'b1;
					state <= S_FETCH;
				end
			end
			S_FETCH: begin
				if (addr_live) begin
					col <= col + 1'b1;
					if (col != LAST) begin
						sram_address <= sram_address + 1'b1;
					end else if (row != LAST) begin
						row <= row + 1'b1;
						sram_address <= next_row;  // Jump to next row
					end else begin
						addr_live <= 1'b0;  // Last address stays on the bus
					end
				end
				if (ram.wr_en && ram.wr_addr == '1) begin
					block_loaded <= 1'b1;
					state <= S_WAIT_DONE;
				end
			end
			S_WAIT_DONE: begin
				if (block_done) begin
					busy <= 1'b0;
					state <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (state == S_IDLE && start) begin
			row_base <= block_base;
		end else if (addr_live && col == LAST) begin
			row_base <= next_row;
		end
	end

	// Read data tracking and pair writes
	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			data_live <= '0;
			odd <= 1'b0;
			ram.wr_en <= 1'b0;
			ram.wr_addr <= '0;
		end else begin
			data_live <= {data_live[SRAM_LATENCY-2:0], addr_live};
			ram.wr_en <= data_valid && odd;
			if (data_valid) begin
				odd <= !odd;
			end
			if (ram.wr_en) begin
				ram.wr_addr <= ram.wr_addr + 1'b1;  // Wraps to 0 after the block
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (data_valid && !odd) begin
			even_buf <= sram_read_data;
		end
		if (data_valid && odd) begin
			ram.wr_data.pair.first <= even_buf;
			ram.wr_data.pair.second <= sram_read_data;
		end
	end

	a_wr_in_fetch: assert property (@(posedge Clock) disable iff (!Resetn)
		ram.wr_en |-> state == S_FETCH);

	// A start during a fetch must not disturb the address walk
	a_start_ignored: assert property (@(posedge Clock) disable iff (!Resetn)
		start && busy && addr_live |=> !addr_live
			|| ({row, col} == $past({row, col}) + 1'b1 && sram_address == row_base + col));

endmodule

// File: src/sprime_ram.sv
module sprime_ram (
	input logic Clock,
	sprime_if.mem mem
);

	localparam int DEPTH = 32;
	localparam int WIDTH = 32;  // Two samples per word

	logic [WIDTH-1:0] words [DEPTH];
	logic [$clog2(DEPTH)-1:0] addr_b;

	// Port b is shared, the fill side has it while writing
	assign addr_b = mem.wr_en ? mem.wr_addr : mem.rd_addr_b;

	always_ff @(posedge Clock) begin
		if (mem.wr_en) begin
			words[addr_b] <= mem.wr_data.raw;
		end
		mem.rd_data_a.raw <= words[mem.rd_addr_a];
		mem.rd_data_b.raw <= words[addr_b];  // Old data on a write cycle
	end

	a_addr_a_known: assert property (@(posedge Clock)
		!mem.wr_en |-> !$isunknown(mem.rd_addr_a));

endmodule

// File: src/row_transform.sv
module row_transform (
	input logic Clock,
	input logic Resetn,
	input logic block_loaded,
	sprime_if.scan ram,
	output logic t_valid,
	output logic [2:0] t_row,
	output logic [2:0] t_col,
	output logic signed [idct_pkg::T_W-1:0] t_data,
	output logic block_done
);
	import idct_pkg::*;

	localparam int CNT_W = $clog2(BLOCK_N);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(BLOCK_N - 1);

	logic scanning;
	logic [CNT_W-1:0] row;
	logic [CNT_W-1:0] col;
	logic half;  // 0 for k = 0..3, 1 for k = 4..7

	// Tags of the words coming back from the RAM
	logic d1_live;
	logic d1_half;
	logic [CNT_W-1:0] d1_row;
	logic [CNT_W-1:0] d1_col;

	// Tags of the operands being multiplied
	logic d2_live;
	logic d2_half;
	logic [CNT_W-1:0] d2_row;
	logic [CNT_W-1:0] d2_col;

	logic signed [SAMPLE_W-1:0] samp [4];
	logic signed [COEF_W-1:0] coef [4];
	logic signed [T_W-1:0] prod [4];
	logic signed [T_W-1:0] sum;
	logic signed [T_W-1:0] acc;  // First half of the current result

	// Word r*4 + 2*half on port a, the next one on port b
	assign ram.rd_addr_a = {row, half, 1'b0};
	assign ram.rd_addr_b = {row, half, 1'b1};

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			scanning <= 1'b0;
			row <= '0;
			col <= '0;
			half <= 1'b0;
		end else if (block_loaded) begin
			scanning <= 1'b1;
			row <= '0;
			col <= '0;
			half <= 1'b0;
		end else if (scanning) begin
			half <= !half;
			if (half) begin
				col <= col + 1'b1;
				if (col == LAST) begin
					row <= row + 1'b1;
					if (row == LAST) begin
						scanning <= 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			d1_live <= 1'b0;
			d2_live <= 1'b0;
			t_valid <= 1'b0;
			block_done <= 1'b0;
		end else begin
			d1_live <= scanning;
			d2_live <= d1_live;
			t_valid <= d2_live && d2_half;
			block_done <= t_valid && t_row == LAST && t_col == LAST;
		end
	end

	always_comb begin
		for (int j = 0; j < 4; j++) begin
			prod[j] = samp[j] * coef[j];
		end
		sum = prod[0] + prod[1] + prod[2] + prod[3];
	end

	always_ff @(posedge Clock) begin
		d1_half <= half;
		d1_row <= row;
		d1_col <= col;
		d2_half <= d1_half;
		d2_row <= d1_row;
		d2_col <= d1_col;

		// Operands for k = 4*half .. 4*half+3
		if (d1_live) begin
			samp[0] <= ram.rd_data_a.pair.first;
			samp[1] <= ram.rd_data_a.pair.second;
			samp[2] <= ram.rd_data_b.pair.first;
			samp[3] <= ram.rd_data_b.pair.second;
			for (int j = 0; j < 4; j++) begin
				coef[j] <= cos_coef({d1_half, 2'(j)}, d1_col);
			end
		end

		if (d2_live) begin
			if (!d2_half) begin
				acc <= sum;
			end else begin
				t_data <= acc + sum;
				t_row <= d2_row;
				t_col <= d2_col;
			end
		end
	end

	a_valid_spacing: assert property (@(posedge Clock) disable iff (!Resetn)
		t_valid |=> !t_valid);

	// Fetch must not hand over a new block mid scan
	a_load_when_idle: assert property (@(posedge Clock) disable iff (!Resetn)
		block_loaded |-> !scanning);

endmodule

// File: src/idct_row_stage.sv
module idct_row_stage #(
	parameter int unsigned ROW_STRIDE = 320
) (
	input logic Clock,
	input logic Resetn,
	input logic start,
	input logic [idct_pkg::SRAM_ADDR_W-1:0] block_base,
	input logic [idct_pkg::SAMPLE_W-1:0] sram_read_data,
	output logic [idct_pkg::SRAM_ADDR_W-1:0] sram_address,
	output logic busy,
	output logic t_valid,
	output logic [2:0] t_row,
	output logic [2:0] t_col,
	output logic signed [idct_pkg::T_W-1:0] t_data,
	output logic done
);

	logic block_loaded;  // Fetch to transform handoff

	sprime_if s_ram ();

	block_fetch #(
		.ROW_STRIDE(ROW_STRIDE)
	) i_fetch (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.block_base(block_base),
		.sram_read_data(sram_read_data),
		.block_done(done),
		.sram_address(sram_address),
		.busy(busy),
		.block_loaded(block_loaded),
		.ram(s_ram.fill)
	);

	sprime_ram i_ram (
		.Clock(Clock),
		.mem(s_ram.mem)
	);

	row_transform i_row (
		.Clock(Clock),
		.Resetn(Resetn),
		.block_loaded(block_loaded),
		.ram(s_ram.scan),
		.t_valid(t_valid),
		.t_row(t_row),
		.t_col(t_col),
		.t_data(t_data),
		.block_done(done)
	);

endmodule

// File: verif/sram_model.sv
module sram_model (
	input logic Clock,
	input logic [idct_pkg::SRAM_ADDR_W-1:0] address,
	input logic capture,  // Record the address seen on this edge
	output logic [idct_pkg::SAMPLE_W-1:0] read_data
);
	import idct_pkg::*;

	logic [SAMPLE_W-1:0] mem [logic [SRAM_ADDR_W-1:0]];
	logic [SAMPLE_W-1:0] pipe [SRAM_LATENCY];
	logic [SRAM_ADDR_W-1:0] seen [$];

	initial begin
		for (int i = 0; i < SRAM_LATENCY; i++) begin
			pipe[i] = '0;
		end
	end

	// Unwritten words read as zero
	always @(posedge Clock) begin
		pipe[0] <= mem.exists(address) ? mem[address] : '0;
		for (int i = 1; i < SRAM_LATENCY; i++) begin
			pipe[i] <= pipe[i-1];
		end
		if (capture) begin
			seen.push_back(address);
		end
	end

	assign read_data = pipe[SRAM_LATENCY-1];

	task automatic load_word(input logic [SRAM_ADDR_W-1:0] addr, input logic [SAMPLE_W-1:0] data);
		mem[addr] = data;
	endtask

	task automatic clear_seen();
		seen.delete();
	endtask

	function automatic int seen_count();
		return seen.size();
	endfunction

	function automatic logic [SRAM_ADDR_W-1:0] seen_address(input int i);
		return seen[i];
	endfunction

endmodule

// File: verif/tb_idct_row_stage.sv
module tb_idct_row_stage;
	import idct_pkg::*;

	localparam int ROW_STRIDE = 320;
	localparam int NUM_BLOCKS = 3;
	localparam real PI = 3.14159265358979;

	logic Clock;
	logic Resetn;
	logic start;
	logic [SRAM_ADDR_W-1:0] block_base;
	logic [SAMPLE_W-1:0] sram_read_data;
	logic [SRAM_ADDR_W-1:0] sram_address;
	logic busy;
	logic t_valid;
	logic [2:0] t_row;
	logic [2:0] t_col;
	logic signed [T_W-1:0] t_data;
	logic done;
	logic capture;

	logic [31:0] lfsr_state = 32'h3344c8b1;
	int coef_ref [8][8];
	int samples [8][8];     // S' of the block in flight
	longint exp_t [64];
	int res_idx = 0;        // Results seen in the current block
	int fetch_cnt = 0;
	int checks = 0;
	int errors = 0;

	idct_row_stage #(
		.ROW_STRIDE(ROW_STRIDE)
	) i_dut (
		.Clock(Clock),
		.Resetn(Resetn),
		.start(start),
		.block_base(block_base),
		.sram_read_data(sram_read_data),
		.sram_address(sram_address),
		.busy(busy),
		.t_valid(t_valid),
		.t_row(t_row),
		.t_col(t_col),
		.t_data(t_data),
		.done(done)
	);

	sram_model i_sram (
		.Clock(Clock),
		.address(sram_address),
		.capture(capture),
		.read_data(sram_read_data)
	);

	always #20 Clock = !Clock;

	// Window of the 64 fetch cycles of a block
	assign capture = busy && fetch_cnt < 64;

	always @(posedge Clock) begin
		if (!busy) begin
			fetch_cnt <= 0;
		end else if (fetch_cnt < 64) begin
			fetch_cnt <= fetch_cnt + 1;
		end
	end

	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	function automatic int reference_coef(input int k, input int c);
		real scale;
		scale = (k == 0) ? 1.0 / $sqrt(2.0) : 1.0;
		return $rtoi(2048.0 * scale * $cos((2 * c + 1) * k * PI / 16.0));  // Truncates toward zero
	endfunction

	task automatic report_fault(input string what);
		errors++;
		$display("Failure at time %0t: %s", $time, what);
	endtask

	task automatic check_value(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[ERROR] time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_idle();
		check_value("busy", 0, busy);
		check_value("t_valid", 0, t_valid);
		check_value("done", 0, done);
		check_value("sram_address", 0, sram_address);
	endtask

	// Random S' with frequent extremes, then the expected T row by row
	task automatic fill_block(input logic [SRAM_ADDR_W-1:0] base);
		logic [2:0] pick;
		logic signed [SAMPLE_W-1:0] s;
		longint acc;
		for (int r = 0; r < 8; r++) begin
			for (int k = 0; k < 8; k++) begin
				pick = 3'(rand_bits(3));
				if (pick == 3'd0) begin
					s = 16'h8000;
				end else if (pick == 3'd1) begin
					s = 16'h7fff;
				end else begin
					s = 16'(rand_bits(16));
				end
				samples[r][k] = s;
				i_sram.load_word(SRAM_ADDR_W'(base + r * ROW_STRIDE + k), s);
			end
		end
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				acc = 0;
				for (int k = 0; k < 8; k++) begin
					acc += longint'(samples[r][k]) * coef_ref[k][c];
				end
				exp_t[r * 8 + c] = acc;
			end
		end
	endtask

	task automatic run_block(input int stray_delay);
		logic [SRAM_ADDR_W-1:0] base;
		logic [SRAM_ADDR_W-1:0] other;
		base = SRAM_ADDR_W'(rand_bits(SRAM_ADDR_W));
		other = SRAM_ADDR_W'(rand_bits(SRAM_ADDR_W));
		fill_block(base);
		res_idx = 0;
		i_sram.clear_seen();
		@(posedge Clock);
		start <= 1'b1;
		block_base <= base;
		@(posedge Clock);
		start <= 1'b0;
		block_base <= other;
		repeat (stray_delay) @(posedge Clock);
		start <= 1'b1;  // Must be ignored while busy
		@(posedge Clock);
		start <= 1'b0;
		do @(posedge Clock); while (done !== 1'b1);
		check_value("result count", 64, res_idx);
		check_value("address count", 64, i_sram.seen_count());
		for (int i = 0; i < i_sram.seen_count() && i < 64; i++) begin
			check_value("sram_address", SRAM_ADDR_W'(base + (i / 8) * ROW_STRIDE + i % 8),
				i_sram.seen_address(i));
		end
		repeat (3) @(posedge Clock);
		check_value("busy", 0, busy);  // No block started by the stray pulse
	endtask

	always @(posedge Clock) begin
		if (Resetn && t_valid) begin
			if (res_idx >= 64) begin
				report_fault("more than 64 results in one block");
			end else begin
				check_value("t_row", res_idx / 8, t_row);
				check_value("t_col", res_idx % 8, t_col);
				check_value("t_data", exp_t[res_idx], t_data);
			end
			res_idx++;
		end
	end

	a_spacing: assert property (@(posedge Clock) disable iff (!Resetn)
		t_valid && !(t_row == 3'd7 && t_col == 3'd7) |=> !t_valid ##1 t_valid)
		else report_fault("results are not two cycles apart");

	a_done_follows: assert property (@(posedge Clock) disable iff (!Resetn)
		t_valid && t_row == 3'd7 && t_col == 3'd7 |=> done)
		else report_fault("done did not follow the last result");

	a_done_only_after_last: assert property (@(posedge Clock) disable iff (!Resetn)
		done |-> $past(t_valid) && $past(t_row) == 3'd7 && $past(t_col) == 3'd7)
		else report_fault("done pulsed without a last result before it");

	a_busy_falls: assert property (@(posedge Clock) disable iff (!Resetn)
		done |=> !busy)
		else report_fault("busy did not fall after done");

	a_address_hold: assert property (@(posedge Clock) disable iff (!Resetn)
		busy && fetch_cnt == 64 |-> $stable(sram_address))
		else report_fault("sram_address moved after the 64th fetch");

	a_quiet_when_idle: assert property (@(posedge Clock) disable iff (!Resetn)
		!busy |-> !t_valid && !done)
		else report_fault("result or done seen while not busy");

	initial begin
		repeat (NUM_BLOCKS * 260 + 100) @(posedge Clock);
		$display("The run timed out waiting for the DUT");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		Clock = 1'b0;
		Resetn = 1'b0;
		start = 1'b0;
		block_base = '0;
		for (int k = 0; k < 8; k++) begin
			for (int c = 0; c < 8; c++) begin
				coef_ref[k][c] = reference_coef(k, c);
			end
		end
		repeat (10) @(posedge Clock);
		Resetn <= 1'b1;
		repeat (3) begin
			@(posedge Clock);
			check_idle();
		end
		run_block(5);    // Stray start during the fetch
		run_block(100);  // Stray start during the transform
		run_block(30);
		repeat (4) @(posedge Clock);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
src/idct_pkg.sv
src/sprime_if.sv
src/block_fetch.sv
src/sprime_ram.sv
src/row_transform.sv
src/idct_row_stage.sv
verif/sram_model.sv
verif/tb_idct_row_stage.sv
